//--- verilog/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Width of a data word, also the PC width
`define DATA_W 32

// Register indices including r15
`define REG_CNT 16

// One shift-add step per multiplier bit
`define MUL_STEPS `DATA_W

// Word address width of instruction and data memories
`define MEM_AW 8

`endif

//--- verilog/isaPkg.sv
`default_nettype none

`include "core_params.svh"

package isaPkg;

  // Raw instruction word as it comes from fetch
  typedef logic [31:0] instrT;

  // Rn, Rd, Rs and Rm fields
  typedef logic [$clog2(`REG_CNT)-1:0] regIdxT;

  // Data-processing immediate, used without rotation
  typedef logic [7:0] imm8T;

  // Load/store offset, always added to the base
  typedef logic [11:0] imm12T;

  // Opcode field, bits 24:21 of a data-processing word
  typedef enum logic [3:0] {
    AND = 4'b0000,
    SUB = 4'b0010,
    ADD = 4'b0100,
    ORR = 4'b1100,
    MOV = 4'b1101
  } opcodeT;

endpackage

`default_nettype wire

//--- verilog/pipePkg.sv
`default_nettype none

`include "core_params.svh"

package pipePkg;

  // Data word on every operand and result path
  typedef logic [`DATA_W-1:0] wordT;

  // Bypass source, order matches the operand mux inputs
  typedef enum logic [1:0] {
    fwdReg = 2'b00,
    fwdWb  = 2'b01,
    fwdMem = 2'b10
  } fwdSelT;

  typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOrr, aluPassB} aluOpT;

  // Multiply sequencer states
  typedef enum logic [1:0] {mulIdle, mulRun, mulDone} mulStateT;

  // Remaining multiply iterations, holds MUL_STEPS itself
  typedef logic [$clog2(`MUL_STEPS):0] stepCntT;

endpackage

`default_nettype wire

//--- verilog/regfile.sv
`default_nettype none

`include "core_params.svh"

module regfile (
  input  logic           clk,
  input  logic           we3,
  input  isaPkg::regIdxT ra1,
  input  isaPkg::regIdxT ra2,
  input  isaPkg::regIdxT wa3,
  input  pipePkg::wordT  wd3,
  input  pipePkg::wordT  r15,
  output pipePkg::wordT  rd1,
  output pipePkg::wordT  rd2
);

  localparam isaPkg::regIdxT pcIdx = isaPkg::regIdxT'(`REG_CNT - 1);

  // r0 to r14 only, the PC lives in fetch
  pipePkg::wordT regs [`REG_CNT-1];

  // Written on the falling edge
  // decode reads the value writeback produced earlier in the same cycle
  always_ff @(negedge clk) begin
    if (we3) begin
      regs[wa3] <= wd3;
    end
  end

  // r15 reads give PC+8 of the instruction in decode
  assign rd1 = (ra1 == pcIdx) ? r15 : regs[ra1];
  assign rd2 = (ra2 == pcIdx) ? r15 : regs[ra2];

endmodule

`default_nettype wire

//--- verilog/controller.sv
`default_nettype none

module controller (
  input  logic           clk,
  input  logic           rstN,
  input  isaPkg::instrT  instrD,
  input  logic           stallE,
  input  logic           flushE,
  input  logic           stallM,
  output pipePkg::aluOpT aluOpE,
  output logic           aluSrcE,
  output logic           isMulE,
  output logic           memWriteM,
  output logic           memToRegW,
  output logic           regWriteW,
  output logic           memToRegE,
  output logic           regWriteE,
  output logic           regWriteM
);

  logic           decodeValid;
  isaPkg::opcodeT opcodeD;
  logic           isMulD, isDpD, isMemD, isLoadD;
  pipePkg::aluOpT aluOpD;
  logic           aluSrcD, memWriteD, regWriteD;
  logic           memWriteE, memToRegM;

  // Decode register still holds its reset word for one cycle
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      decodeValid <= 1'b0;
    end else begin
      decodeValid <= 1'b1;
    end
  end

  // ========================================================================
  // Decode
  // ========================================================================
  assign opcodeD = isaPkg::opcodeT'(instrD[24:21]);
  // MUL: bits 27:22 clear, 7:4 = 1001
  assign isMulD  = decodeValid && (instrD[27:22] == 6'b0) && (instrD[7:4] == 4'b1001);
  assign isDpD   = decodeValid && (instrD[27:26] == 2'b00) && !isMulD;
  assign isMemD  = decodeValid && (instrD[27:26] == 2'b01);
  assign isLoadD = isMemD && instrD[20];

  always_comb begin
    if (isDpD) begin
      case (opcodeD)
        isaPkg::SUB: aluOpD = pipePkg::aluSub;
        isaPkg::AND: aluOpD = pipePkg::aluAnd;
        isaPkg::ORR: aluOpD = pipePkg::aluOrr;
        isaPkg::MOV: aluOpD = pipePkg::aluPassB;
        default:     aluOpD = pipePkg::aluAdd;
      endcase
    end else begin
      // Base plus offset for loads and stores
      aluOpD = pipePkg::aluAdd;
    end
  end

  // Bit 25 picks the immediate, memory ops always use the offset
  assign aluSrcD   = isMemD || (isDpD && instrD[25]);
  assign memWriteD = isMemD && !instrD[20];
  // STR writes no register
  assign regWriteD = isDpD || isMulD || isLoadD;

  // ========================================================================
  // Execute
  // ========================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      aluOpE    <= pipePkg::aluAdd;
      aluSrcE   <= 1'b0;
      isMulE    <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      regWriteE <= 1'b0;
    end else if (flushE) begin
      // Bubble, only the effect bits matter
      isMulE    <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
      regWriteE <= 1'b0;
    end else if (!stallE) begin
      aluOpE    <= aluOpD;
      aluSrcE   <= aluSrcD;
      isMulE    <= isMulD;
      memWriteE <= memWriteD;
      memToRegE <= isLoadD;
      regWriteE <= regWriteD;
    end
  end

  // ========================================================================
  // Memory and writeback
  // ========================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
      regWriteM <= 1'b0;
      memToRegW <= 1'b0;
      regWriteW <= 1'b0;
    end else begin
      // Held execute stage sends a bubble on
      if (!stallM) begin
        memWriteM <= memWriteE && !stallE;
        memToRegM <= memToRegE;
        regWriteM <= regWriteE && !stallE;
      end
      memToRegW <= memToRegM;
      regWriteW <= regWriteM && !stallM;
    end
  end

endmodule

`default_nettype wire

//--- verilog/hazardUnit.sv
`default_nettype none

module hazardUnit (
  input  isaPkg::regIdxT   ra1D,
  input  isaPkg::regIdxT   ra2D,
  input  isaPkg::regIdxT   ra1E,
  input  isaPkg::regIdxT   ra2E,
  input  isaPkg::regIdxT   wa3E,
  input  isaPkg::regIdxT   wa3M,
  input  isaPkg::regIdxT   wa3W,
  input  logic             regWriteE,
  input  logic             regWriteM,
  input  logic             regWriteW,
  input  logic             memToRegE,
  input  logic             mulBusy,
  output pipePkg::fwdSelT  forwardAE,
  output pipePkg::fwdSelT  forwardBE,
  output logic             stallF,
  output logic             stallD,
  output logic             flushE,
  output logic             stallE,
  output logic             stallM
);

  logic ldStall;

  // Youngest producer wins, memory before writeback
  function automatic pipePkg::fwdSelT pickSrc(input isaPkg::regIdxT ra);
    if (regWriteM && (wa3M == ra)) begin
      pickSrc = pipePkg::fwdMem;
    end else if (regWriteW && (wa3W == ra)) begin
      pickSrc = pipePkg::fwdWb;
    end else begin
      pickSrc = pipePkg::fwdReg;
    end
  endfunction

  always_comb begin
    forwardAE = pickSrc(ra1E);
    forwardBE = pickSrc(ra2E);
  end

  // Load in execute feeding decode, data not ready until writeback
  assign ldStall = memToRegE && regWriteE && ((wa3E == ra1D) || (wa3E == ra2D));

  // Multiply holds fetch, decode and execute
  assign stallF = ldStall || mulBusy;
  assign stallD = ldStall || mulBusy;
  assign flushE = ldStall && !mulBusy;
  assign stallE = mulBusy;
  // Memory answers in one cycle, this stage never waits
  assign stallM = 1'b0;

endmodule

`default_nettype wire

//--- verilog/multSequencer.sv
`default_nettype none

module multSequencer (
  input  logic clk,
  input  logic rstN,
  input  logic isMulE,
  input  logic lastStep,
  output logic loadCnt,
  output logic stepEn,
  output logic mulBusy
);

  pipePkg::mulStateT state, stateNext;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state <= pipePkg::mulIdle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      pipePkg::mulIdle: begin
        if (isMulE) begin
          stateNext = pipePkg::mulRun;
        end
      end
      pipePkg::mulRun: begin
        if (lastStep) begin
          stateNext = pipePkg::mulDone;
        end
      end
      // Product ready, execute moves on this cycle
      default: stateNext = pipePkg::mulIdle;
    endcase
  end

  // Operands captured on the first cycle while forwarding is still valid
  assign loadCnt = (state == pipePkg::mulIdle) && isMulE;
  assign stepEn  = (state == pipePkg::mulRun);
  assign mulBusy = loadCnt || stepEn;

endmodule

`default_nettype wire

//--- verilog/multIterCounter.sv
`default_nettype none

`include "core_params.svh"

module multIterCounter (
  input  logic clk,
  input  logic rstN,
  input  logic loadCnt,
  input  logic stepEn,
  output logic lastStep
);

  pipePkg::stepCntT stepsLeft;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      stepsLeft <= '0;
    end else if (loadCnt) begin
      stepsLeft <= pipePkg::stepCntT'(`MUL_STEPS);
    end else if (stepEn) begin
      stepsLeft <= stepsLeft - 1'b1;
    end
  end

  // One step left, this one ends the run
  assign lastStep = stepEn && (stepsLeft == pipePkg::stepCntT'(1));

endmodule

`default_nettype wire

//--- verilog/multiplier.sv
`default_nettype none

module multiplier (
  input  logic          clk,
  input  logic          rstN,
  input  logic          loadCnt,
  input  logic          stepEn,
  input  pipePkg::wordT multiplicand,
  input  pipePkg::wordT multiplierIn,
  output pipePkg::wordT mulProduct
);

  pipePkg::wordT acc, mcand, mplier;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      acc    <= '0;
      mcand  <= '0;
      mplier <= '0;
    end else if (loadCnt) begin
      acc    <= '0;
      mcand  <= multiplicand;
      mplier <= multiplierIn;
    end else if (stepEn) begin
      // Add the shifted multiplicand for each set bit
      // bits above 31 drop off, MUL keeps the low word
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  assign mulProduct = acc;

endmodule

`default_nettype wire

//--- verilog/datapath.sv
`default_nettype none

module datapath (
  input  logic            clk,
  input  logic            rstN,
  output pipePkg::wordT   pcF,
  input  isaPkg::instrT   instrF,
  output isaPkg::instrT   instrD,
  input  pipePkg::aluOpT  aluOpE,
  input  logic            aluSrcE,
  input  logic            isMulE,
  input  logic            memToRegW,
  input  logic            regWriteW,
  input  pipePkg::fwdSelT forwardAE,
  input  pipePkg::fwdSelT forwardBE,
  input  logic            stallF,
  input  logic            stallD,
  input  logic            flushE,
  input  logic            stallE,
  input  logic            stallM,
  output pipePkg::wordT   srcAE,
  output pipePkg::wordT   srcBE,
  input  pipePkg::wordT   mulProduct,
  output pipePkg::wordT   dataAdr,
  output pipePkg::wordT   writeData,
  input  pipePkg::wordT   readData,
  output pipePkg::wordT   resultW,
  output isaPkg::regIdxT  ra1D,
  output isaPkg::regIdxT  ra2D,
  output isaPkg::regIdxT  ra1E,
  output isaPkg::regIdxT  ra2E,
  output isaPkg::regIdxT  wa3E,
  output isaPkg::regIdxT  wa3M,
  output isaPkg::regIdxT  wa3W
);

  pipePkg::wordT  pcPlus4F;
  logic           isMulD, isMemD;
  isaPkg::imm8T   imm8D;
  isaPkg::imm12T  imm12D;
  isaPkg::regIdxT destD;
  pipePkg::wordT  extImmD, rd1D, rd2D;
  pipePkg::wordT  rd1E, rd2E, immE, writeDataE, aluOutE, resultE;
  pipePkg::wordT  aluOutM, writeDataM;
  pipePkg::wordT  aluOutW, readDataW;

  // Operand bypass, same selection on both source paths
  function automatic pipePkg::wordT bypass(
    input pipePkg::fwdSelT sel,
    input pipePkg::wordT   regVal,
    input pipePkg::wordT   wbVal,
    input pipePkg::wordT   memVal
  );
    case (sel)
      pipePkg::fwdWb:  bypass = wbVal;
      pipePkg::fwdMem: bypass = memVal;
      default:         bypass = regVal;
    endcase
  endfunction

  // ========================================================================
  // Fetch
  // ========================================================================
  // PC only steps by four
  assign pcPlus4F = pcF + pipePkg::wordT'(4);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pcF <= '0;
    end else if (!stallF) begin
      pcF <= pcPlus4F;
    end
  end

  // ========================================================================
  // Decode
  // ========================================================================
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      instrD <= '0;
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

  assign isMulD = (instrD[27:22] == 6'b0) && (instrD[7:4] == 4'b1001);
  assign isMemD = (instrD[27:26] == 2'b01);

  // Register addresses by class
  always_comb begin
    if (isMulD) begin
      // MUL Rd, Rm, Rs with Rd in bits 19:16
      ra1D  = instrD[3:0];
      ra2D  = instrD[11:8];
      destD = instrD[19:16];
    end else begin
      ra1D  = instrD[19:16];
      // Store data comes from Rd
      ra2D  = isMemD ? instrD[15:12] : instrD[3:0];
      destD = instrD[15:12];
    end
  end

  assign imm8D   = instrD[7:0];
  assign imm12D  = instrD[11:0];
  assign extImmD = isMemD ? pipePkg::wordT'(imm12D) : pipePkg::wordT'(imm8D);

  // r15 of the decode instruction is fetch PC + 4
  regfile u_regfile (
    .clk (clk),
    .we3 (regWriteW),
    .ra1 (ra1D),
    .ra2 (ra2D),
    .wa3 (wa3W),
    .wd3 (resultW),
    .r15 (pcPlus4F),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  // ========================================================================
  // Execute
  // ========================================================================
  always_ff @(posedge clk) begin
    if (!stallE) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
      immE <= extImmD;
    end
  end

  // Address path feeding the hazard comparators
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else if (flushE) begin
      ra1E <= '0;
      ra2E <= '0;
      wa3E <= '0;
    end else if (!stallE) begin
      ra1E <= ra1D;
      ra2E <= ra2D;
      wa3E <= destD;
    end
  end

  assign srcAE      = bypass(forwardAE, rd1E, resultW, aluOutM);
  assign writeDataE = bypass(forwardBE, rd2E, resultW, aluOutM);
  assign srcBE      = aluSrcE ? immE : writeDataE;

  always_comb begin
    case (aluOpE)
      pipePkg::aluSub:   aluOutE = srcAE - srcBE;
      pipePkg::aluAnd:   aluOutE = srcAE & srcBE;
      pipePkg::aluOrr:   aluOutE = srcAE | srcBE;
      pipePkg::aluPassB: aluOutE = srcBE;
      default:           aluOutE = srcAE + srcBE;
    endcase
  end

  // Product is final in the cycle execute releases the multiply
  assign resultE = isMulE ? mulProduct : aluOutE;

  // ========================================================================
  // Memory
  // ========================================================================
  always_ff @(posedge clk) begin
    if (!stallM) begin
      aluOutM    <= resultE;
      writeDataM <= writeDataE;
    end
  end

  assign dataAdr   = aluOutM;
  assign writeData = writeDataM;

  // ========================================================================
  // Writeback
  // ========================================================================
  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readData;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wa3M <= '0;
      wa3W <= '0;
    end else begin
      if (!stallM) begin
        wa3M <= wa3E;
      end
      wa3W <= wa3M;
    end
  end

  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

`default_nettype wire

//--- verilog/armCore.sv
`default_nettype none

module armCore (
  input  logic           clk,
  input  logic           rstN,
  output pipePkg::wordT  pcF,
  input  isaPkg::instrT  instrF,
  output pipePkg::wordT  dataAdr,
  output pipePkg::wordT  writeData,
  output logic           memWrite,
  input  pipePkg::wordT  readData,
  output logic           regWriteW,
  output isaPkg::regIdxT wa3W,
  output pipePkg::wordT  resultW
);

  isaPkg::instrT   instrD;
  pipePkg::aluOpT  aluOpE;
  logic            aluSrcE, isMulE, memToRegW;
  logic            memToRegE, regWriteE, regWriteM;
  pipePkg::fwdSelT forwardAE, forwardBE;
  logic            stallF, stallD, flushE, stallE, stallM;
  isaPkg::regIdxT  ra1D, ra2D, ra1E, ra2E, wa3E, wa3M;
  // Multiply group
  logic            loadCnt, stepEn, mulBusy, lastStep;
  pipePkg::wordT   srcAE, srcBE, mulProduct;

  controller u_controller (
    .clk       (clk),
    .rstN      (rstN),
    .instrD    (instrD),
    .stallE    (stallE),
    .flushE    (flushE),
    .stallM    (stallM),
    .aluOpE    (aluOpE),
    .aluSrcE   (aluSrcE),
    .isMulE    (isMulE),
    .memWriteM (memWrite),
    .memToRegW (memToRegW),
    .regWriteW (regWriteW),
    .memToRegE (memToRegE),
    .regWriteE (regWriteE),
    .regWriteM (regWriteM)
  );

  hazardUnit u_hazardUnit (
    .ra1D      (ra1D),
    .ra2D      (ra2D),
    .ra1E      (ra1E),
    .ra2E      (ra2E),
    .wa3E      (wa3E),
    .wa3M      (wa3M),
    .wa3W      (wa3W),
    .regWriteE (regWriteE),
    .regWriteM (regWriteM),
    .regWriteW (regWriteW),
    .memToRegE (memToRegE),
    .mulBusy   (mulBusy),
    .forwardAE (forwardAE),
    .forwardBE (forwardBE),
    .stallF    (stallF),
    .stallD    (stallD),
    .flushE    (flushE),
    .stallE    (stallE),
    .stallM    (stallM)
  );

  multSequencer u_multSequencer (
    .clk      (clk),
    .rstN     (rstN),
    .isMulE   (isMulE),
    .lastStep (lastStep),
    .loadCnt  (loadCnt),
    .stepEn   (stepEn),
    .mulBusy  (mulBusy)
  );

  multIterCounter u_multIterCounter (
    .clk      (clk),
    .rstN     (rstN),
    .loadCnt  (loadCnt),
    .stepEn   (stepEn),
    .lastStep (lastStep)
  );

  // Rm times Rs, both after bypass
  multiplier u_multiplier (
    .clk          (clk),
    .rstN         (rstN),
    .loadCnt      (loadCnt),
    .stepEn       (stepEn),
    .multiplicand (srcAE),
    .multiplierIn (srcBE),
    .mulProduct   (mulProduct)
  );

  datapath u_datapath (
    .clk        (clk),
    .rstN       (rstN),
    .pcF        (pcF),
    .instrF     (instrF),
    .instrD     (instrD),
    .aluOpE     (aluOpE),
    .aluSrcE    (aluSrcE),
    .isMulE     (isMulE),
    .memToRegW  (memToRegW),
    .regWriteW  (regWriteW),
    .forwardAE  (forwardAE),
    .forwardBE  (forwardBE),
    .stallF     (stallF),
    .stallD     (stallD),
    .flushE     (flushE),
    .stallE     (stallE),
    .stallM     (stallM),
    .srcAE      (srcAE),
    .srcBE      (srcBE),
    .mulProduct (mulProduct),
    .dataAdr    (dataAdr),
    .writeData  (writeData),
    .readData   (readData),
    .resultW    (resultW),
    .ra1D       (ra1D),
    .ra2D       (ra2D),
    .ra1E       (ra1E),
    .ra2E       (ra2E),
    .wa3E       (wa3E),
    .wa3M       (wa3M),
    .wa3W       (wa3W)
  );

endmodule

`default_nettype wire

//--- sim/armCore_props.sv
`default_nettype none

`include "core_params.svh"

module armCore_props (
  input logic            clk,
  input logic            rstN,
  input pipePkg::wordT   pcF,
  input logic            memWrite,
  input logic            regWriteW,
  input isaPkg::regIdxT  wa3W,
  input logic            mulBusy,
  input pipePkg::fwdSelT forwardAE
);
  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed assertions
  int failCnt = 0;

  // Quiet outputs while reset is held and on the first edge after release
  quietAroundReset: assert property (
    @(posedge clk) (!rstN || $rose(rstN)) |-> (!memWrite && !regWriteW)
  ) else begin
    $error("memWrite or regWriteW high around reset");
    failCnt++;
  end

  // Fetch starts from address zero
  pcZeroInReset: assert property (@(posedge clk) !rstN |-> (pcF == '0))
    else begin
      $error("pcF not zero during reset");
      failCnt++;
    end

  // Multiply holds fetch
  pcHeldByMul: assert property (
    @(posedge clk) disable iff (!rstN) mulBusy |=> $stable(pcF)
  ) else begin
    $error("pcF moved while a multiply was busy");
    failCnt++;
  end

  // r15 is never a writeback target
  noPcWrite: assert property (
    @(posedge clk) disable iff (!rstN)
    regWriteW |-> (wa3W != isaPkg::regIdxT'(`REG_CNT - 1))
  ) else begin
    $error("register write to r15");
    failCnt++;
  end

  fwdAKnown: assert property (
    @(posedge clk) disable iff (!rstN) !$isunknown(forwardAE)
  ) else begin
    $error("forwardAE has unknown bits");
    failCnt++;
  end

endmodule

bind armCore armCore_props u_armCore_props (
  .clk       (clk),
  .rstN      (rstN),
  .pcF       (pcF),
  .memWrite  (memWrite),
  .regWriteW (regWriteW),
  .wa3W      (wa3W),
  .mulBusy   (mulBusy),
  .forwardAE (forwardAE)
);

`default_nettype wire

//--- sim/tb_armCore.sv
`default_nettype none

`include "core_params.svh"

module tb_armCore;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 16;
  localparam int RowMax      = 32;
  localparam int MemWords    = 2 ** `MEM_AW;
  // MOV r0, r0
  localparam isaPkg::instrT Nop = 32'hE1A0_0000;

  logic           clk;
  logic           rstN;
  pipePkg::wordT  pcF, dataAdr, writeData, readData, resultW;
  isaPkg::instrT  instrF;
  logic           memWrite, regWriteW;
  isaPkg::regIdxT wa3W;

  isaPkg::instrT imem [MemWords];
  pipePkg::wordT dmem [MemWords];

  // Program table, one row per instruction
  isaPkg::instrT  rowInstr   [RowMax];
  logic           rowIsStore [RowMax];
  isaPkg::regIdxT rowDest    [RowMax];
  pipePkg::wordT  rowAdr     [RowMax];
  pipePkg::wordT  rowValue   [RowMax];
  int             rowCnt = 0;

  // Expected effects in program order
  isaPkg::regIdxT expRegIdx [$];
  pipePkg::wordT  expRegVal [$];
  pipePkg::wordT  expStAdr  [$];
  pipePkg::wordT  expStData [$];

  int errorCnt = 0, retireCnt = 0, storeCnt = 0, regRowCnt = 0;
  bit tableLoaded = 1'b0;

  armCore u_armCore (
    .clk       (clk),
    .rstN      (rstN),
    .pcF       (pcF),
    .instrF    (instrF),
    .dataAdr   (dataAdr),
    .writeData (writeData),
    .memWrite  (memWrite),
    .readData  (readData),
    .regWriteW (regWriteW),
    .wa3W      (wa3W),
    .resultW   (resultW)
  );

  // ==========================================================================
  // Clock and memory models
  // ==========================================================================
  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Both memories answer combinationally on word addresses
  assign instrF   = imem[pcF[`MEM_AW+1:2]];
  assign readData = dmem[dataAdr[`MEM_AW+1:2]];

  always @(posedge clk) begin
    if (memWrite) begin
      dmem[dataAdr[`MEM_AW+1:2]] <= writeData;
    end
  end

  // ==========================================================================
  // Instruction encoders
  // ==========================================================================
  function automatic isaPkg::instrT dpImm(isaPkg::opcodeT op, isaPkg::regIdxT rd,
                                          isaPkg::regIdxT rn, isaPkg::imm8T imm);
    dpImm = {4'hE, 2'b00, 1'b1, op, 1'b0, rn, rd, 4'h0, imm};
  endfunction

  function automatic isaPkg::instrT dpReg(isaPkg::opcodeT op, isaPkg::regIdxT rd,
                                          isaPkg::regIdxT rn, isaPkg::regIdxT rm);
    dpReg = {4'hE, 2'b00, 1'b0, op, 1'b0, rn, rd, 8'h00, rm};
  endfunction

  // Pre-indexed, offset added, word access
  function automatic isaPkg::instrT memOp(logic load, isaPkg::regIdxT rd,
                                          isaPkg::regIdxT rn, isaPkg::imm12T off);
    memOp = {4'hE, 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, load, rn, rd, off};
  endfunction

  function automatic isaPkg::instrT mulOp(isaPkg::regIdxT rd, isaPkg::regIdxT rm,
                                          isaPkg::regIdxT rs);
    mulOp = {4'hE, 6'b000000, 1'b0, 1'b0, rd, 4'h0, rs, 4'b1001, rm};
  endfunction

  task automatic addRegRow(isaPkg::instrT instr, isaPkg::regIdxT rd, pipePkg::wordT val);
    rowInstr[rowCnt]   = instr;
    rowIsStore[rowCnt] = 1'b0;
    rowDest[rowCnt]    = rd;
    rowAdr[rowCnt]     = '0;
    rowValue[rowCnt]   = val;
    rowCnt++;
  endtask

  task automatic addStoreRow(isaPkg::instrT instr, pipePkg::wordT adr, pipePkg::wordT val);
    rowInstr[rowCnt]   = instr;
    rowIsStore[rowCnt] = 1'b1;
    rowDest[rowCnt]    = '0;
    rowAdr[rowCnt]     = adr;
    rowValue[rowCnt]   = val;
    rowCnt++;
  endtask

  // ==========================================================================
  // Program with expected effects
  // ==========================================================================
  task automatic buildProgram();
    pipePkg::wordT ldA, ldB, prod;
    // Operands of the multiply come from random words at 0x60 and 0x64
    ldA  = dmem[8'h18];
    ldB  = dmem[8'h19];
    prod = ldA * ldB;
    addRegRow(dpImm(isaPkg::MOV, 0, 0, 8'h00), 0, 32'h0);
    addRegRow(dpImm(isaPkg::MOV, 1, 0, 8'h40), 1, 32'h40);
    // Back to back, operands from memory and writeback stages
    addRegRow(dpImm(isaPkg::ADD, 2, 1, 8'h25), 2, 32'h65);
    addRegRow(dpReg(isaPkg::SUB, 3, 2, 1), 3, 32'h25);
    addRegRow(dpImm(isaPkg::AND, 4, 3, 8'h0F), 4, 32'h05);
    addRegRow(dpImm(isaPkg::ORR, 5, 4, 8'h30), 5, 32'h35);
    addRegRow(dpReg(isaPkg::MOV, 6, 0, 5), 6, 32'h35);
    addRegRow(dpImm(isaPkg::SUB, 7, 6, 8'h40), 7, 32'hFFFF_FFF5);
    addRegRow(dpReg(isaPkg::AND, 8, 7, 2), 8, 32'h65);
    addRegRow(dpReg(isaPkg::ADD, 9, 8, 7), 9, 32'h5A);
    addRegRow(dpReg(isaPkg::ORR, 10, 9, 3), 10, 32'h7F);
    // Store, then a load of the same word and a load-use bubble
    addStoreRow(memOp(1'b0, 10, 1, 12'h008), 32'h48, 32'h7F);
    addRegRow(memOp(1'b1, 11, 1, 12'h008), 11, 32'h7F);
    addRegRow(dpImm(isaPkg::ADD, 12, 11, 8'h01), 12, 32'h80);
    // Multiply of two random words, low word only
    addRegRow(memOp(1'b1, 2, 1, 12'h020), 2, ldA);
    addRegRow(memOp(1'b1, 3, 1, 12'h024), 3, ldB);
    addRegRow(mulOp(4, 2, 3), 4, prod);
    addRegRow(dpReg(isaPkg::ADD, 5, 4, 12), 5, prod + 32'h80);
    addStoreRow(memOp(1'b0, 5, 1, 12'h010), 32'h50, prod + 32'h80);
    addRegRow(memOp(1'b1, 6, 1, 12'h010), 6, prod + 32'h80);
    addRegRow(dpReg(isaPkg::SUB, 7, 6, 4), 7, 32'h80);
    addRegRow(mulOp(8, 7, 7), 8, 32'h4000);
    addRegRow(dpReg(isaPkg::ORR, 9, 8, 0), 9, 32'h4000);
  endtask

  // ==========================================================================
  // Checks
  // ==========================================================================
  task automatic checkWord(string sig, pipePkg::wordT got, pipePkg::wordT exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %h, expected %h", $time, sig, got, exp);
      errorCnt++;
    end
  endtask

  task automatic checkReg(string sig, isaPkg::regIdxT got, isaPkg::regIdxT exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got r%0d, expected r%0d", $time, sig, got, exp);
      errorCnt++;
    end
  endtask

  task automatic checkBit(string sig, logic got, logic exp);
    if (got !== exp) begin
      $display("[FAIL] %0t ns %s: got %b, expected %b", $time, sig, got, exp);
      errorCnt++;
    end
  endtask

  // Retire port, sampled mid-cycle where it is stable
  always @(negedge clk) begin
    if (rstN && regWriteW) begin
      if (expRegIdx.size() != 0) begin
        checkReg("wa3W", wa3W, expRegIdx.pop_front());
        checkWord("resultW", resultW, expRegVal.pop_front());
        retireCnt++;
      end else if (wa3W == '0) begin
        // Filler past the program keeps r0 at zero
        checkWord("resultW", resultW, '0);
      end else begin
        $display("Extra register write to r%0d at %0t ns", wa3W, $time);
        errorCnt++;
      end
    end
  end

  always @(negedge clk) begin
    if (rstN && memWrite) begin
      if (expStAdr.size() != 0) begin
        checkWord("dataAdr", dataAdr, expStAdr.pop_front());
        checkWord("writeData", writeData, expStData.pop_front());
        storeCnt++;
      end else begin
        $display("Unexpected store to address %h at %0t ns", dataAdr, $time);
        errorCnt++;
      end
    end
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    rstN = 1'b0;
    void'($urandom(34));
    for (int a = 0; a < MemWords; a++) begin
      dmem[a] = $urandom;
      imem[a] = Nop;
    end
    buildProgram();
    for (int i = 0; i < rowCnt; i++) begin
      imem[i] = rowInstr[i];
      if (rowIsStore[i]) begin
        expStAdr.push_back(rowAdr[i]);
        expStData.push_back(rowValue[i]);
      end else begin
        expRegIdx.push_back(rowDest[i]);
        expRegVal.push_back(rowValue[i]);
        regRowCnt++;
      end
    end
    tableLoaded = 1'b1;

    for (int c = 0; c < ResetCycles; c++) begin
      @(posedge clk);
      @(negedge clk);
      checkWord("pcF", pcF, '0);
      checkBit("memWrite", memWrite, 1'b0);
      checkBit("regWriteW", regWriteW, 1'b0);
    end
    @(posedge clk);
    rstN <= 1'b1;
    // State is still the reset state one half cycle after release
    @(negedge clk);
    checkWord("pcF", pcF, '0);
    checkBit("memWrite", memWrite, 1'b0);
    checkBit("regWriteW", regWriteW, 1'b0);

    // Last row has left writeback once fetch is four words past the program
    while (pcF < pipePkg::wordT'((rowCnt + 4) * 4)) begin
      @(negedge clk);
    end
    // A few more cycles catch stray writes
    repeat (8) @(posedge clk);
    errorCnt += u_armCore.u_armCore_props.failCnt;
    if (retireCnt != regRowCnt) begin
      $display("Retired %0d register writes, program has %0d", retireCnt, regRowCnt);
      errorCnt++;
    end
    if (expStAdr.size() != 0) begin
      $display("%0d expected stores never appeared", expStAdr.size());
      errorCnt++;
    end
    $display("Retired %0d, stored %0d, errors %0d", retireCnt, storeCnt, errorCnt);
    if (errorCnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Worst case every row a multiply
  initial begin
    time limit;
    wait (tableLoaded);
    limit = (rowCnt * (`MUL_STEPS + 6) + ResetCycles) * ClkPeriod;
    #(limit);
    $display("Timeout after %0t ns with %0d retirements still pending",
             $time, expRegIdx.size());
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/regfile.sv
verilog/controller.sv
verilog/hazardUnit.sv
verilog/multSequencer.sv
verilog/multIterCounter.sv
verilog/multiplier.sv
verilog/datapath.sv
verilog/armCore.sv
sim/armCore_props.sv
sim/tb_armCore.sv
